/* Bender.yml */
package:
  name: letc_core

sources:
  - core_pkg.sv
  - core_stage_if.sv
  - core_s2_control.sv
  - core_s2_gen_imm.sv
  - core_s2_alu.sv
  - core_s2_reg_file.sv
  - core_s1.sv
  - core_s2.sv
  - core_top.sv
  - target: test
    files:
      - tb_core_top.sv

/* core_pkg.sv */
// RV32I core shared types
`default_nettype none

package core_pkg;

    // Data and address word
    typedef logic [31:0] word_t;
    // Register index
    typedef logic [4:0] reg_idx_t;

    // Fetch address out of reset
    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } instr_format_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Operand 2 straight through, for LUI
        ALU_PASS2
    } alu_op_e;

    // Branch comparisons, same order as funct3 minus the gap
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_op_e;

    // Operand and write-back source selects
    typedef enum logic {OP1_RS1, OP1_PC} alu_op1_src_e;
    typedef enum logic {OP2_RS2, OP2_IMM} alu_op2_src_e;
    typedef enum logic {RD_SRC_ALU, RD_SRC_NEXT_PC} rd_src_e;

endpackage : core_pkg

`default_nettype wire

/* core_s1.sv */
// Fetch stage
`default_nettype none

module core_s1 #(
    parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,

    core_stage_if.s1        stage,

    // Wishbone classic master, instruction side
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::word_t wb_adr,
    input  core_pkg::word_t wb_dat_r,
    input  logic            wb_ack,

    output logic            halted
);

    typedef enum logic [1:0] {
        FETCH,
        PRESENT,
        HALTED
    } state_e;

    state_e          state;
    core_pkg::word_t pc_q;
    core_pkg::word_t instr_q;

    // Read only port
    assign wb_we  = 1'b0;
    assign wb_adr = pc_q;

    assign stage.valid = (state == PRESENT);
    assign stage.pc    = pc_q;
    assign stage.instr = instr_q;
    assign halted      = (state == HALTED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= FETCH;
            pc_q   <= reset_pc;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!wb_cyc) begin
                        // Only right after reset
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= PRESENT;
                    end
                end
                PRESENT: begin
                    if (stage.accept) begin
                        if (stage.halt_req) begin
                            state <= HALTED;
                        end else begin
                            // Redirect or step, then fetch again at once
                            pc_q   <= stage.branch_en ? stage.branch_target : pc_q + 32'd4;
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                            state  <= FETCH;
                        end
                    end
                end
                // Halted, nothing more happens until reset
                default: begin
                end
            endcase
        end
    end

    // Latch the word in the ack cycle
    always_ff @(posedge clk) begin
        if (state == FETCH && wb_cyc && wb_ack) begin
            instr_q <= wb_dat_r;
        end
    end

    // Strobe only inside a cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);

    // Instruction is never offered while the bus is still busy
    assert property (@(posedge clk) disable iff (!rst_n) stage.valid |-> !wb_cyc);

    // Address held until the slave acks
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)));

endmodule : core_s1

`default_nettype wire

/* core_s2.sv */
// Decode and execute stage
`default_nettype none

module core_s2 (
    input  logic               clk,
    input  logic               rst_n,

    core_stage_if.s2           stage,

    // Retirement trace
    output logic               retire_valid,
    output core_pkg::word_t    retire_pc,
    output core_pkg::reg_idx_t retire_rd,
    output core_pkg::word_t    retire_wd
);

    // Decoder outputs
    core_pkg::reg_idx_t      rs1_idx;
    core_pkg::reg_idx_t      rs2_idx;
    core_pkg::reg_idx_t      rd_idx;
    logic                    rd_we;
    core_pkg::instr_format_e instr_format;
    core_pkg::alu_op_e       alu_operation;
    core_pkg::alu_op1_src_e  alu_op1_src;
    core_pkg::alu_op2_src_e  alu_op2_src;
    core_pkg::rd_src_e       rd_src;
    core_pkg::cmp_op_e       cmp_operation;
    logic                    cond_branch_en;
    logic                    uncond_branch_en;
    logic                    illegal_instr;

    // Datapath
    core_pkg::word_t imm;
    core_pkg::word_t rs1_rd;
    core_pkg::word_t rs2_rd;
    core_pkg::word_t rd_wd;
    logic            rf_we;
    core_pkg::word_t alu_operand_1;
    core_pkg::word_t alu_operand_2;
    core_pkg::word_t alu_result;
    core_pkg::word_t next_seq_pc;
    logic            cmp_result;

    core_s2_control core_s2_control_inst (
        .instr(stage.instr),
        .*
    );

    core_s2_gen_imm core_s2_gen_imm_inst (
        .instr(stage.instr),
        .*
    );

    core_s2_reg_file core_s2_reg_file_inst (
        .rd_we(rf_we),
        .*
    );

    core_s2_alu core_s2_alu_inst (.*);

    assign next_seq_pc = stage.pc + 32'd4;

    // Operand and write-back muxes
    assign alu_operand_1 = (alu_op1_src == core_pkg::OP1_PC) ? stage.pc : rs1_rd;
    assign alu_operand_2 = (alu_op2_src == core_pkg::OP2_IMM) ? imm : rs2_rd;
    assign rd_wd = (rd_src == core_pkg::RD_SRC_NEXT_PC) ? next_seq_pc : alu_result;
    // Commit only the word stage 1 is offering
    assign rf_we = stage.valid && rd_we;

    // Branch comparator
    always_comb begin
        case (cmp_operation)
            core_pkg::CMP_EQ:  cmp_result = (rs1_rd == rs2_rd);
            core_pkg::CMP_NE:  cmp_result = (rs1_rd != rs2_rd);
            core_pkg::CMP_LT:  cmp_result = ($signed(rs1_rd) < $signed(rs2_rd));
            core_pkg::CMP_GE:  cmp_result = ($signed(rs1_rd) >= $signed(rs2_rd));
            core_pkg::CMP_LTU: cmp_result = (rs1_rd < rs2_rd);
            default:           cmp_result = (rs1_rd >= rs2_rd);
        endcase
    end

    // Never stalls
    assign stage.accept = stage.valid;
    assign stage.halt_req = stage.valid && illegal_instr;
    assign stage.branch_en = stage.valid && (uncond_branch_en || (cond_branch_en && cmp_result));
    // JALR needs bit 0 cleared, harmless for the others
    assign stage.branch_target = {alu_result[31:1], 1'b0};

    // Halting word does not retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= stage.valid && !illegal_instr;
        end
    end

    // Trace payload, rd and wd zero when nothing is written
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            retire_pc <= stage.pc;
            retire_rd <= rd_we ? rd_idx : '0;
            retire_wd <= rd_we ? rd_wd : '0;
        end
    end

    // Decoder drops branch enables on illegal words
    assert property (@(posedge clk) disable iff (!rst_n)
        !(stage.halt_req && stage.branch_en));

endmodule : core_s2

`default_nettype wire

/* core_s2_alu.sv */
// RV32I integer ALU
`default_nettype none

module core_s2_alu (
    input  core_pkg::word_t   alu_operand_1,
    input  core_pkg::word_t   alu_operand_2,
    input  core_pkg::alu_op_e alu_operation,
    output core_pkg::word_t   alu_result
);

    logic [4:0] shamt;

    // Only low five bits shift
    assign shamt = alu_operand_2[4:0];

    always_comb begin
        case (alu_operation)
            core_pkg::ALU_ADD:  alu_result = alu_operand_1 + alu_operand_2;
            core_pkg::ALU_SUB:  alu_result = alu_operand_1 - alu_operand_2;
            core_pkg::ALU_SLL:  alu_result = alu_operand_1 << shamt;
            core_pkg::ALU_SLT:
                alu_result = {31'd0, $signed(alu_operand_1) < $signed(alu_operand_2)};
            core_pkg::ALU_SLTU: alu_result = {31'd0, alu_operand_1 < alu_operand_2};
            core_pkg::ALU_XOR:  alu_result = alu_operand_1 ^ alu_operand_2;
            core_pkg::ALU_SRL:  alu_result = alu_operand_1 >> shamt;
            // Arithmetic shift keeps the sign
            core_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_operand_1) >>> shamt);
            core_pkg::ALU_OR:   alu_result = alu_operand_1 | alu_operand_2;
            core_pkg::ALU_AND:  alu_result = alu_operand_1 & alu_operand_2;
            default:            alu_result = alu_operand_2;
        endcase
    end

endmodule : core_s2_alu

`default_nettype wire

/* core_s2_control.sv */
// RV32I instruction decoder
`default_nettype none

module core_s2_control (
    input  core_pkg::word_t         instr,

    output core_pkg::reg_idx_t      rs1_idx,
    output core_pkg::reg_idx_t      rs2_idx,
    output core_pkg::reg_idx_t      rd_idx,
    output logic                    rd_we,
    output core_pkg::instr_format_e instr_format,
    output core_pkg::alu_op_e       alu_operation,
    output core_pkg::alu_op1_src_e  alu_op1_src,
    output core_pkg::alu_op2_src_e  alu_op2_src,
    output core_pkg::rd_src_e       rd_src,
    output core_pkg::cmp_op_e       cmp_operation,
    output logic                    cond_branch_en,
    output logic                    uncond_branch_en,
    output logic                    illegal_instr
);

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    assign opcode  = core_pkg::opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    // Shared by OP and OP_IMM, alt picks SUB or SRA
    function automatic core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        rd_we            = 1'b0;
        instr_format     = core_pkg::FMT_R;
        alu_operation    = core_pkg::ALU_ADD;
        alu_op1_src      = core_pkg::OP1_RS1;
        alu_op2_src      = core_pkg::OP2_RS2;
        rd_src           = core_pkg::RD_SRC_ALU;
        cmp_operation    = core_pkg::CMP_EQ;
        cond_branch_en   = 1'b0;
        uncond_branch_en = 1'b0;
        illegal_instr    = 1'b0;

        case (opcode)
            core_pkg::OPCODE_OP: begin
                rd_we         = 1'b1;
                alu_operation = alu_from_funct3(funct3, funct7[5]);
                // Alternate funct7 only for SUB and SRA
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    illegal_instr = 1'b1;
                end
            end
            core_pkg::OPCODE_OP_IMM: begin
                rd_we         = 1'b1;
                instr_format  = core_pkg::FMT_I;
                alu_op2_src   = core_pkg::OP2_IMM;
                alu_operation = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
                // Shift amount encodings constrain the upper bits
                if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
                    illegal_instr = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
                    illegal_instr = 1'b1;
                end
            end
            core_pkg::OPCODE_LUI: begin
                rd_we         = 1'b1;
                instr_format  = core_pkg::FMT_U;
                alu_op2_src   = core_pkg::OP2_IMM;
                alu_operation = core_pkg::ALU_PASS2;
            end
            core_pkg::OPCODE_AUIPC: begin
                rd_we        = 1'b1;
                instr_format = core_pkg::FMT_U;
                alu_op1_src  = core_pkg::OP1_PC;
                alu_op2_src  = core_pkg::OP2_IMM;
            end
            core_pkg::OPCODE_JAL: begin
                rd_we            = 1'b1;
                instr_format     = core_pkg::FMT_J;
                alu_op1_src      = core_pkg::OP1_PC;
                alu_op2_src      = core_pkg::OP2_IMM;
                rd_src           = core_pkg::RD_SRC_NEXT_PC;
                uncond_branch_en = 1'b1;
            end
            core_pkg::OPCODE_JALR: begin
                rd_we            = 1'b1;
                instr_format     = core_pkg::FMT_I;
                alu_op2_src      = core_pkg::OP2_IMM;
                rd_src           = core_pkg::RD_SRC_NEXT_PC;
                uncond_branch_en = 1'b1;
                illegal_instr    = (funct3 != 3'b000);
            end
            core_pkg::OPCODE_BRANCH: begin
                instr_format   = core_pkg::FMT_B;
                alu_op1_src    = core_pkg::OP1_PC;
                alu_op2_src    = core_pkg::OP2_IMM;
                cond_branch_en = 1'b1;
                case (funct3)
                    3'b000:  cmp_operation = core_pkg::CMP_EQ;
                    3'b001:  cmp_operation = core_pkg::CMP_NE;
                    3'b100:  cmp_operation = core_pkg::CMP_LT;
                    3'b101:  cmp_operation = core_pkg::CMP_GE;
                    3'b110:  cmp_operation = core_pkg::CMP_LTU;
                    3'b111:  cmp_operation = core_pkg::CMP_GEU;
                    default: illegal_instr = 1'b1;
                endcase
            end
            // EBREAK is the halt request, ECALL and CSR ops unsupported
            core_pkg::OPCODE_SYSTEM: illegal_instr = 1'b1;
            default:                 illegal_instr = 1'b1;
        endcase

        // Illegal word has no side effects
        if (illegal_instr) begin
            rd_we            = 1'b0;
            cond_branch_en   = 1'b0;
            uncond_branch_en = 1'b0;
        end
    end

endmodule : core_s2_control

`default_nettype wire

/* core_s2_gen_imm.sv */
// Immediate generator
`default_nettype none

module core_s2_gen_imm (
    input  core_pkg::word_t         instr,
    input  core_pkg::instr_format_e instr_format,
    output core_pkg::word_t         imm
);

    logic sign;

    // Sign bit always sits in instr[31]
    assign sign = instr[31];

    always_comb begin
        case (instr_format)
            core_pkg::FMT_I: imm = {{20{sign}}, instr[31:20]};
            core_pkg::FMT_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch and jump offsets are even
            core_pkg::FMT_B: imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            core_pkg::FMT_U: imm = {instr[31:12], 12'h000};
            core_pkg::FMT_J: imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            // R format has none
            default:         imm = '0;
        endcase
    end

endmodule : core_s2_gen_imm

`default_nettype wire

/* core_s2_reg_file.sv */
// Integer register file
`default_nettype none

module core_s2_reg_file (
    input  logic               clk,
    input  logic               rst_n,

    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs1_rd,
    output core_pkg::word_t    rs2_rd,

    input  core_pkg::reg_idx_t rd_idx,
    input  core_pkg::word_t    rd_wd,
    input  logic               rd_we
);

    // x1 to x31 only, x0 has no storage
    logic [31:1][31:0] regs;

    // Asynchronous reads
    assign rs1_rd = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_rd = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (rd_we && rd_idx != '0) begin
            regs[rd_idx] <= rd_wd;
        end
    end

    // Write aimed at x0 leaves every register untouched
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_we && rd_idx == '0) |=> $stable(regs));

endmodule : core_s2_reg_file

`default_nettype wire

/* core_stage_if.sv */
// Stage 1 to stage 2 handshake
`default_nettype none

interface core_stage_if;

    // Forward path, fetched instruction and its address
    logic            valid;
    core_pkg::word_t pc;
    core_pkg::word_t instr;

    // Return path
    logic            accept;
    logic            branch_en;
    core_pkg::word_t branch_target;
    // Stop fetching for good
    logic            halt_req;

    modport s1 (
        output valid, pc, instr,
        input  accept, branch_en, branch_target, halt_req
    );

    modport s2 (
        input  valid, pc, instr,
        output accept, branch_en, branch_target, halt_req
    );

endinterface : core_stage_if

`default_nettype wire

/* core_top.sv */
// Two stage RV32I core
`default_nettype none

module core_top #(
    parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,

    // Instruction memory, Wishbone classic
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output core_pkg::word_t    wb_adr,
    input  core_pkg::word_t    wb_dat_r,
    input  logic               wb_ack,

    // Retirement trace
    output logic               retire_valid,
    output core_pkg::word_t    retire_pc,
    output core_pkg::reg_idx_t retire_rd,
    output core_pkg::word_t    retire_wd,

    output logic               halted
);

    // Handshake between fetch and execute
    core_stage_if stage_bus ();

    core_s1 #(
        .reset_pc(reset_pc)
    ) core_s1_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .stage   (stage_bus.s1),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .halted  (halted)
    );

    core_s2 core_s2_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage       (stage_bus.s2),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_wd   (retire_wd)
    );

endmodule : core_top

`default_nettype wire

/* letc_core.f */
core_pkg.sv
core_stage_if.sv
core_s2_control.sv
core_s2_gen_imm.sv
core_s2_alu.sv
core_s2_reg_file.sv
core_s1.sv
core_s2.sv
core_top.sv
tb_core_top.sv

/* tb_core_top.sv */
// Core testbench with Wishbone memory model
`default_nettype none

module tb_core_top;

    localparam int MEM_WORDS    = 64;
    localparam int RETIRE_WAIT  = 50;
    localparam int HALT_WAIT    = 50;
    localparam int QUIET_CYCLES = 20;

    // Major opcodes used by the program
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] HALT_PC     = 32'h0000_0088;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wd;
    logic        halted;

    // Instruction memory and ack delay source
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lfsr;
    int          wait_left;

    // Program table, one row per retired instruction
    string       test_name [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_wd [$];

    int pass_count;
    int fail_count;
    bit aborted;

    core_top #(
        .reset_pc(core_pkg::RESET_PC_DEFAULT)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_wd   (retire_wd),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Two bits, so 0 to 3 wait states
    task automatic draw_delay(output int d);
        lfsr = lfsr_step(lfsr);
        d = lfsr[0];
        lfsr = lfsr_step(lfsr);
        d = 2 * d + lfsr[0];
    endtask

    // Opcode zero keeps stray fetches illegal
    function automatic logic [31:0] fill_word(input int unsigned idx);
        logic [31:0] h;
        h = idx * 32'h9e37_79b1;
        return {h[31:7] ^ h[24:0], 7'b0000000};
    endfunction

    // Outside the array reads as an illegal word
    function automatic logic [31:0] mem_read(input logic [31:0] adr);
        if (adr[31:8] != '0) begin
            return '0;
        end
        return mem[adr[7:2]];
    endfunction

    // Instruction word builders, RV32I field layout
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Row goes into the table, word goes into memory at its pc
    task automatic add_test(input string name, input logic [31:0] pc, input logic [31:0] instr,
                            input logic [4:0] rd, input logic [31:0] wd);
        test_name.push_back(name);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_wd.push_back(wd);
        mem[pc[7:2]] = instr;
    endtask

    task automatic build_program();
        // x1 = 5, x2 = -3
        add_test("addi_x1", 32'h00, i_type(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, 32'h5);
        add_test("addi_neg", 32'h04, i_type(12'hffd, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2,
                 32'hffff_fffd);
        add_test("add", 32'h08, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h2);
        add_test("sub", 32'h0c, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h8);
        add_test("xor", 32'h10, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 5'd5, 32'hffff_fff8);
        add_test("or", 32'h14, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, 32'hffff_fffd);
        add_test("and", 32'h18, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), 5'd7, 32'h5);
        // -3 against 5, signed then unsigned
        add_test("slt", 32'h1c, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 5'd8, 32'h1);
        add_test("sltu", 32'h20, r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 5'd9, 32'h0);
        add_test("sll", 32'h24, r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd10), 5'd10, 32'ha0);
        add_test("srl", 32'h28, r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd11), 5'd11, 32'h07ff_ffff);
        add_test("sra", 32'h2c, r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd12), 5'd12, 32'hffff_ffff);
        add_test("xori", 32'h30, i_type(12'h0ff, 5'd1, 3'b100, 5'd13, OP_IMM), 5'd13, 32'hfa);
        add_test("slti", 32'h34, i_type(12'hffe, 5'd2, 3'b010, 5'd14, OP_IMM), 5'd14, 32'h1);
        add_test("lui", 32'h38, u_type(20'h12345, 5'd15, OP_LUI), 5'd15, 32'h1234_5000);
        add_test("auipc", 32'h3c, u_type(20'h00001, 5'd16, OP_AUIPC), 5'd16, 32'h103c);
        // x0 write shows its value, then x0 still reads zero
        add_test("addi_x0", 32'h40, i_type(12'd7, 5'd1, 3'b000, 5'd0, OP_IMM), 5'd0, 32'hc);
        add_test("add_x0", 32'h44, r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd17), 5'd17, 32'h5);
        // Branches alternate taken and not taken
        add_test("beq_taken", 32'h48, b_type(13'd8, 5'd1, 5'd1, 3'b000), 5'd0, 32'h0);
        add_test("bne_not", 32'h50, b_type(13'd8, 5'd1, 5'd1, 3'b001), 5'd0, 32'h0);
        add_test("blt_taken", 32'h54, b_type(13'd12, 5'd1, 5'd2, 3'b100), 5'd0, 32'h0);
        add_test("bge_not", 32'h60, b_type(13'd16, 5'd1, 5'd2, 3'b101), 5'd0, 32'h0);
        add_test("bltu_taken", 32'h64, b_type(13'd8, 5'd2, 5'd1, 3'b110), 5'd0, 32'h0);
        add_test("bgeu_not", 32'h6c, b_type(13'd8, 5'd2, 5'd1, 3'b111), 5'd0, 32'h0);
        add_test("jal", 32'h70, j_type(21'd16, 5'd18), 5'd18, 32'h74);
        // Odd base, JALR lands on 0xb0
        add_test("addi_odd", 32'h80, i_type(12'h0a1, 5'd0, 3'b000, 5'd19, OP_IMM), 5'd19, 32'ha1);
        add_test("jalr", 32'h84, i_type(12'h010, 5'd19, 3'b000, 5'd20, OP_JALR), 5'd20, 32'h88);
        add_test("addi_link", 32'hb0, i_type(12'd1, 5'd20, 3'b000, 5'd21, OP_IMM), 5'd21, 32'h89);
        // Backward by 44 to the EBREAK
        add_test("bge_back", 32'hb4, b_type(13'h1fd4, 5'd2, 5'd1, 3'b101), 5'd0, 32'h0);
        mem[HALT_PC[7:2]] = EBREAK_WORD;
    endtask

    // Slave side, ack after the drawn number of wait states
    always @(posedge clk) begin
        #2;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (rst_n && wb_cyc && wb_stb) begin
            // Instruction side only ever reads
            if (wb_we !== 1'b0) begin
                $display("Core drove a write on the instruction bus at address %h", wb_adr);
                fail_count++;
            end
            if (wait_left < 0) begin
                draw_delay(wait_left);
            end
            if (wait_left == 0) begin
                wb_dat_r  = mem_read(wb_adr);
                wb_ack    = 1'b1;
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        int idx;
        int cycles;
        int errs;
        bit seen;

        rst_n      = 1'b0;
        wb_ack     = 1'b0;
        wb_dat_r   = '0;
        lfsr       = 32'h30a1_5bac;
        wait_left  = -1;
        pass_count = 0;
        fail_count = 0;
        aborted    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        build_program();

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        idx = 0;
        while (idx < test_name.size() && !aborted) begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < RETIRE_WAIT) begin
                @(negedge clk);
                seen = retire_valid;
                cycles++;
            end
            if (!seen) begin
                $display("Test %s never retired within %0d cycles", test_name[idx], RETIRE_WAIT);
                fail_count++;
                aborted = 1'b1;
            end else begin
                errs = 0;
                if (retire_pc !== exp_pc[idx]) begin
                    $display("CHECK FAILED %s retire_pc expected %h actual %h",
                             test_name[idx], exp_pc[idx], retire_pc);
                    errs++;
                end
                if (retire_rd !== exp_rd[idx]) begin
                    $display("CHECK FAILED %s retire_rd expected %h actual %h",
                             test_name[idx], exp_rd[idx], retire_rd);
                    errs++;
                end
                if (retire_wd !== exp_wd[idx]) begin
                    $display("CHECK FAILED %s retire_wd expected %h actual %h",
                             test_name[idx], exp_wd[idx], retire_wd);
                    errs++;
                end
                if (errs == 0) begin
                    $display("PASS %s", test_name[idx]);
                    pass_count++;
                end else begin
                    $display("FAIL %s", test_name[idx]);
                    fail_count++;
                end
            end
            idx++;
        end

        // EBREAK at HALT_PC stops the core without a retire
        if (!aborted) begin
            cycles = 0;
            errs   = 0;
            while (!halted && cycles < HALT_WAIT) begin
                @(negedge clk);
                if (retire_valid) begin
                    $display("Unexpected retire at pc %h before the halt", retire_pc);
                    errs++;
                end
                cycles++;
            end
            if (!halted) begin
                $display("Test halt_on_ebreak never saw halted within %0d cycles", HALT_WAIT);
                fail_count++;
                aborted = 1'b1;
            end else if (errs != 0) begin
                $display("FAIL halt_on_ebreak");
                fail_count++;
            end else begin
                $display("PASS halt_on_ebreak");
                pass_count++;
            end
        end

        // Bus and trace stay quiet once halted
        if (!aborted) begin
            errs = 0;
            for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
                @(negedge clk);
                if (retire_valid || wb_cyc) begin
                    $display("Core was still active %0d cycles after halting", cycles);
                    errs++;
                end
            end
            if (errs == 0) begin
                $display("PASS quiet_after_halt");
                pass_count++;
            end else begin
                $display("FAIL quiet_after_halt");
                fail_count++;
            end
        end

        $display("Tests done, %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_core_top

`default_nettype wire
